// ==== Bender.yml ====
package:
  name: riscvMulti

sources:
  - rtl/riscvPkg.sv
  - rtl/riscvAlu.sv
  - rtl/riscvControl.sv
  - rtl/riscvDatapath.sv
  - rtl/riscvTop.sv
  - target: test
    files:
      - tb/riscvTbModels.sv
      - tb/riscvTb.sv

// ==== riscvMulti.f ====
rtl/riscvPkg.sv
rtl/riscvAlu.sv
rtl/riscvControl.sv
rtl/riscvDatapath.sv
rtl/riscvTop.sv
tb/riscvTbModels.sv
tb/riscvTb.sv

// ==== rtl/riscvAlu.sv ====
module riscvAlu (
	input riscvPkg::word_t a,
	input riscvPkg::word_t b,
	input riscvPkg::aluOp_e op,
	output riscvPkg::word_t result,
	output logic zero
);
	import riscvPkg::*;

	logic [4:0] shamt;
	logic lessThan;
	logic lessThanU;

	// shifts only look at the low five bits
	assign shamt = b[4:0];
	assign lessThan = $signed(a) < $signed(b);
	assign lessThanU = a < b;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluSlt: result = {31'b0, lessThan};
			aluSltu: result = {31'b0, lessThanU};
			aluSll: result = a << shamt;
			aluSrl: result = a >> shamt;
			aluSra: result = word_t'($signed(a) >>> shamt);
			// lui
			aluPassB: result = b;
			default: result = '0;
		endcase
	end

	// beq/bne compare via sub
	assign zero = (result == '0);

endmodule

// ==== rtl/riscvControl.sv ====
module riscvControl (
	input logic CLK,
	input logic rst,
	input logic [6:0] opcode,
	input logic [2:0] funct3,
	input logic funct7b5,
	input riscvPkg::word_t instr,
	input logic aluZero,
	output logic pcWrite,
	output logic pcSrcAlu,
	output logic irWrite,
	output riscvPkg::aluASel_e aluASel,
	output riscvPkg::aluBSel_e aluBSel,
	output riscvPkg::aluOp_e aluOp,
	output riscvPkg::wbSel_e wbSel,
	output logic rfWe,
	output logic dMemWen,
	output logic iMemCsn,
	output logic dMemCsn,
	output logic halt,
	output riscvPkg::word_t numInst
);
	import riscvPkg::*;

	cpuState_e state;
	cpuState_e stateNext;
	aluOp_e funcOp;
	logic branchTaken;
	logic retire;

	always_ff @(posedge CLK) begin
		if (rst)
			state <= stFetch;
		else
			state <= stateNext;
	end

	always_comb begin
		stateNext = state;
		case (state)
			stFetch: stateNext = stDecode;
			stDecode: begin
				case (opcode)
					OPC_OP: stateNext = stExecR;
					OPC_OPIMM: stateNext = stExecI;
					OPC_LUI: stateNext = stExecLui;
					OPC_LOAD, OPC_STORE: stateNext = stMemAddr;
					OPC_BRANCH: stateNext = stBranch;
					OPC_JAL: stateNext = stJal;
					OPC_JALR: stateNext = stJalr;
					OPC_SYSTEM: stateNext = (instr == EBREAK_WORD) ? stHalted : stFetch;
					// anything else retires as a nop
					default: stateNext = stFetch;
				endcase
			end
			stExecR, stExecI, stExecLui: stateNext = stWriteAlu;
			stMemAddr: stateNext = (opcode == OPC_STORE) ? stMemWrite : stMemRead;
			stMemRead: stateNext = stWriteMem;
			// only rst leaves this
			stHalted: stateNext = stHalted;
			default: stateNext = stFetch;
		endcase
	end

	// alu decode, shared by R and I forms
	always_comb begin
		case (funct3)
			F3_ADDSUB: funcOp = (opcode == OPC_OP && funct7b5) ? aluSub : aluAdd;
			F3_SLL: funcOp = aluSll;
			F3_SLT: funcOp = aluSlt;
			F3_SLTU: funcOp = aluSltu;
			F3_XOR: funcOp = aluXor;
			F3_SR: funcOp = funct7b5 ? aluSra : aluSrl;
			F3_OR: funcOp = aluOr;
			F3_AND: funcOp = aluAnd;
		endcase
	end

	always_comb begin
		case (funct3)
			F3_BEQ: branchTaken = aluZero;
			F3_BNE: branchTaken = !aluZero;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		pcWrite = 1'b0;
		pcSrcAlu = 1'b0;
		irWrite = 1'b0;
		aluASel = aSelRegA;
		aluBSel = bSelRegB;
		aluOp = aluAdd;
		wbSel = wbAluOut;
		rfWe = 1'b0;
		case (state)
			stFetch: begin
				// pc + 4 through the alu
				irWrite = 1'b1;
				aluASel = aSelPc;
				aluBSel = bSelFour;
				pcWrite = 1'b1;
				pcSrcAlu = 1'b1;
			end
			stDecode: begin
				// branch/jal target lands in ALUOut
				aluASel = aSelPc;
				aluBSel = bSelImm;
			end
			stExecR: aluOp = funcOp;
			stExecI: begin
				aluBSel = bSelImm;
				aluOp = funcOp;
			end
			stExecLui: begin
				aluASel = aSelZero;
				aluBSel = bSelImm;
				aluOp = aluPassB;
			end
			stMemAddr: aluBSel = bSelImm;
			stWriteAlu: rfWe = 1'b1;
			stWriteMem: begin
				rfWe = 1'b1;
				wbSel = wbMemData;
			end
			stBranch: begin
				// target taken from ALUOut
				aluOp = aluSub;
				pcWrite = branchTaken;
			end
			stJal: begin
				pcWrite = 1'b1;
				rfWe = 1'b1;
				wbSel = wbPcPlus4;
			end
			stJalr: begin
				aluBSel = bSelImm;
				pcWrite = 1'b1;
				pcSrcAlu = 1'b1;
				rfWe = 1'b1;
				wbSel = wbPcPlus4;
			end
			default: ;
		endcase
	end

	assign iMemCsn = (state != stFetch);
	assign dMemCsn = !(state == stMemRead || state == stMemWrite);
	assign dMemWen = (state != stMemWrite);
	assign halt = (state == stHalted);

	// last cycle of each instruction
	assign retire = (state == stWriteAlu) || (state == stWriteMem) ||
		(state == stMemWrite) || (state == stBranch) || (state == stJal) ||
		(state == stJalr) || (state == stDecode && stateNext == stFetch);

	always_ff @(posedge CLK) begin
		if (rst)
			numInst <= '0;
		else if (retire)
			numInst <= numInst + 32'd1;
	end

endmodule

// ==== rtl/riscvDatapath.sv ====
module riscvDatapath (
	input logic CLK,
	input logic rst,
	input riscvPkg::word_t iMemData,
	input riscvPkg::word_t dMemDi,
	input riscvPkg::word_t rfRd1,
	input riscvPkg::word_t rfRd2,
	input riscvPkg::word_t aluResult,
	input logic pcWrite,
	input logic pcSrcAlu,
	input logic irWrite,
	input riscvPkg::aluASel_e aluASel,
	input riscvPkg::aluBSel_e aluBSel,
	input riscvPkg::wbSel_e wbSel,
	output riscvPkg::addr_t pc,
	output riscvPkg::word_t instr,
	output logic [6:0] opcode,
	output logic [2:0] funct3,
	output logic funct7b5,
	output riscvPkg::regIdx_t rfRa1,
	output riscvPkg::regIdx_t rfRa2,
	output riscvPkg::regIdx_t rfWa,
	output riscvPkg::word_t rfWd,
	output riscvPkg::word_t aluA,
	output riscvPkg::word_t aluB,
	output riscvPkg::addr_t dMemAddr,
	output riscvPkg::word_t dMemDout
);
	import riscvPkg::*;

	addr_t instrPc;
	addr_t curPc;
	addr_t pcNext;
	word_t regA;
	word_t regB;
	word_t aluOut;
	word_t mdr;
	word_t immI;
	word_t immS;
	word_t immB;
	word_t immJ;
	word_t immU;
	word_t imm;

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc <= RESET_PC;
			instrPc <= RESET_PC;
			instr <= '0;
		end else begin
			if (pcWrite)
				pc <= pcNext;
			// pc of the instruction in flight
			if (irWrite) begin
				instr <= iMemData;
				instrPc <= pc;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			regA <= '0;
			regB <= '0;
			aluOut <= '0;
			mdr <= '0;
		end else begin
			regA <= rfRd1;
			regB <= rfRd2;
			aluOut <= aluResult;
			mdr <= dMemDi;
		end
	end

	// targets are always even, so bit 0 is dropped here (jalr needs it)
	assign pcNext = pcSrcAlu ? {aluResult[11:1], 1'b0} : aluOut[11:0];

	// live pc while fetching, latched copy afterwards
	assign curPc = irWrite ? pc : instrPc;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7b5 = instr[30];
	assign rfRa1 = instr[19:15];
	assign rfRa2 = instr[24:20];
	assign rfWa = instr[11:7];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign immU = {instr[31:12], 12'b0};

	always_comb begin
		case (opcode)
			OPC_STORE: imm = immS;
			OPC_BRANCH: imm = immB;
			OPC_JAL: imm = immJ;
			OPC_LUI: imm = immU;
			// loads, op-imm, jalr
			default: imm = immI;
		endcase
	end

	always_comb begin
		case (aluASel)
			aSelPc: aluA = {20'b0, curPc};
			aSelRegA: aluA = regA;
			default: aluA = '0;
		endcase
	end

	always_comb begin
		case (aluBSel)
			bSelRegB: aluB = regB;
			bSelImm: aluB = imm;
			default: aluB = 32'd4;
		endcase
	end

	// pc already holds the return address after fetch
	always_comb begin
		case (wbSel)
			wbMemData: rfWd = mdr;
			wbPcPlus4: rfWd = {20'b0, pc};
			default: rfWd = aluOut;
		endcase
	end

	assign dMemAddr = aluOut[13:2];
	assign dMemDout = regB;

endmodule

// ==== rtl/riscvPkg.sv ====
package riscvPkg;

	typedef logic [31:0] word_t;
	typedef logic [11:0] addr_t;
	typedef logic [4:0] regIdx_t;

	// base opcodes, instr[6:0]
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// funct3 for register and immediate ALU ops
	localparam logic [2:0] F3_ADDSUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct3 for branches
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	localparam word_t EBREAK_WORD = 32'h0010_0073;
	localparam addr_t RESET_PC = '0;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt,
		aluSltu, aluSll, aluSrl, aluSra, aluPassB
	} aluOp_e;

	typedef enum logic [3:0] {
		stFetch, stDecode, stExecR, stExecI, stExecLui,
		stMemAddr, stMemRead, stMemWrite, stWriteAlu, stWriteMem,
		stBranch, stJal, stJalr, stHalted
	} cpuState_e;

	typedef enum logic [1:0] {
		aSelPc,
		aSelRegA,
		aSelZero
	} aluASel_e;

	typedef enum logic [1:0] {
		bSelRegB,
		bSelImm,
		bSelFour
	} aluBSel_e;

	typedef enum logic [1:0] {
		wbAluOut,
		wbMemData,
		wbPcPlus4
	} wbSel_e;

endpackage

// ==== rtl/riscvTop.sv ====
module riscvTop (
	input logic CLK,
	input logic rst,
	output logic iMemCsn,
	output riscvPkg::addr_t iMemAddr,
	input riscvPkg::word_t iMemData,
	output logic dMemCsn,
	input riscvPkg::word_t dMemDi,
	output riscvPkg::word_t dMemDout,
	output riscvPkg::addr_t dMemAddr,
	output logic dMemWen,
	output logic [3:0] dMemBe,
	output logic rfWe,
	output riscvPkg::regIdx_t rfRa1,
	output riscvPkg::regIdx_t rfRa2,
	output riscvPkg::regIdx_t rfWa,
	input riscvPkg::word_t rfRd1,
	input riscvPkg::word_t rfRd2,
	output riscvPkg::word_t rfWd,
	output logic halt,
	output riscvPkg::word_t numInst,
	output riscvPkg::word_t outputPort
);
	import riscvPkg::*;

	logic pcWrite;
	logic pcSrcAlu;
	logic irWrite;
	aluASel_e aluASel;
	aluBSel_e aluBSel;
	aluOp_e aluOp;
	wbSel_e wbSel;
	word_t instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic funct7b5;
	word_t aluA;
	word_t aluB;
	word_t aluResult;
	logic aluZero;

	riscvControl u_riscvControl (
		.CLK(CLK), .rst(rst), .opcode(opcode), .funct3(funct3), .funct7b5(funct7b5),
		.instr(instr), .aluZero(aluZero), .pcWrite(pcWrite), .pcSrcAlu(pcSrcAlu),
		.irWrite(irWrite), .aluASel(aluASel), .aluBSel(aluBSel), .aluOp(aluOp),
		.wbSel(wbSel), .rfWe(rfWe), .dMemWen(dMemWen), .iMemCsn(iMemCsn),
		.dMemCsn(dMemCsn), .halt(halt), .numInst(numInst)
	);

	riscvDatapath u_riscvDatapath (
		.CLK(CLK), .rst(rst), .iMemData(iMemData), .dMemDi(dMemDi), .rfRd1(rfRd1),
		.rfRd2(rfRd2), .aluResult(aluResult), .pcWrite(pcWrite), .pcSrcAlu(pcSrcAlu),
		.irWrite(irWrite), .aluASel(aluASel), .aluBSel(aluBSel), .wbSel(wbSel),
		.pc(iMemAddr), .instr(instr), .opcode(opcode), .funct3(funct3),
		.funct7b5(funct7b5), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(rfWa), .rfWd(rfWd),
		.aluA(aluA), .aluB(aluB), .dMemAddr(dMemAddr), .dMemDout(dMemDout)
	);

	riscvAlu u_riscvAlu (
		.a(aluA), .b(aluB), .op(aluOp), .result(aluResult), .zero(aluZero)
	);

	// full-word accesses only
	assign dMemBe = 4'b1111;
	assign outputPort = rfWd;

endmodule

// ==== tb/riscvTb.sv ====
module riscvTb;
	import riscvPkg::*;

	logic CLK;
	logic rst;
	logic iMemCsn;
	addr_t iMemAddr;
	word_t iMemData;
	logic dMemCsn;
	word_t dMemDi;
	word_t dMemDout;
	addr_t dMemAddr;
	logic dMemWen;
	logic [3:0] dMemBe;
	logic rfWe;
	regIdx_t rfRa1;
	regIdx_t rfRa2;
	regIdx_t rfWa;
	word_t rfRd1;
	word_t rfRd2;
	word_t rfWd;
	logic halt;
	word_t numInst;
	word_t outputPort;

	word_t rngState;
	addr_t fetchTrace [0:255];
	word_t expData [0:4095];
	bit expValid [0:4095];
	int traceLen;
	int fetchIdx;
	int expStores;
	int storeCount;
	int expRetired;
	int progAddr;
	int resultOff;
	int lastSlot;
	int timeoutCycles;
	logic progLoaded;

	riscvTop u_riscvTop (
		.CLK(CLK), .rst(rst), .iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemData(iMemData),
		.dMemCsn(dMemCsn), .dMemDi(dMemDi), .dMemDout(dMemDout), .dMemAddr(dMemAddr),
		.dMemWen(dMemWen), .dMemBe(dMemBe), .rfWe(rfWe), .rfRa1(rfRa1), .rfRa2(rfRa2),
		.rfWa(rfWa), .rfRd1(rfRd1), .rfRd2(rfRd2), .rfWd(rfWd), .halt(halt),
		.numInst(numInst), .outputPort(outputPort)
	);

	// instruction memory is word indexed from the byte address
	riscvTbMem u_iMem (
		.CLK(CLK), .csn(iMemCsn), .wen(1'b1), .addr({2'b00, iMemAddr[11:2]}),
		.din(32'h0), .dout(iMemData)
	);

	riscvTbMem u_dMem (
		.CLK(CLK), .csn(dMemCsn), .wen(dMemWen), .addr(dMemAddr),
		.din(dMemDout), .dout(dMemDi)
	);

	riscvTbRegFile u_regFile (
		.CLK(CLK), .we(rfWe), .ra1(rfRa1), .ra2(rfRa2), .wa(rfWa), .wd(rfWd),
		.rd1(rfRd1), .rd2(rfRd2)
	);

	always #2 CLK = ~CLK;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic reportValue(input string name, input word_t exp, input word_t act);
		abortRun($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	function automatic word_t nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic word_t shiftRightArith(input word_t v, input logic [4:0] s);
		word_t fill;
		fill = v[31] ? ~(32'hffff_ffff >> s) : 32'h0;
		return (v >> s) | fill;
	endfunction

	function automatic word_t lessSigned(input word_t x, input word_t y);
		return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
	endfunction

	// RV32I instruction formats
	function automatic word_t encR(input logic [6:0] f7, input regIdx_t rs2,
			input regIdx_t rs1, input logic [2:0] f3, input regIdx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t encI(input logic [11:0] imm, input regIdx_t rs1,
			input logic [2:0] f3, input regIdx_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t encS(input logic [11:0] imm, input regIdx_t rs2,
			input regIdx_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t encB(input logic [12:0] off, input regIdx_t rs2,
			input regIdx_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic word_t encJ(input logic [20:0] off, input regIdx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	function automatic word_t encAddi(input regIdx_t rd, input regIdx_t rs1,
			input logic [11:0] imm);
		return encI(imm, rs1, 3'b000, rd, OPC_OPIMM);
	endfunction

	// runs marks instructions that the program flow reaches
	task automatic emit(input word_t w, input bit runs);
		u_iMem.mem[progAddr / 4] = w;
		if (runs) begin
			fetchTrace[traceLen] = addr_t'(progAddr);
			traceLen++;
			if (w != EBREAK_WORD)
				expRetired++;
		end
		progAddr += 4;
	endtask

	task automatic storeResult(input regIdx_t rs, input word_t value);
		emit(encS(12'(resultOff), rs, 5'd0), 1'b1);
		expData[resultOff / 4] = value;
		expValid[resultOff / 4] = 1'b1;
		expStores++;
		lastSlot = resultOff;
		resultOff += 4;
	endtask

	task automatic aluR(input logic [2:0] f3, input logic alt, input word_t exp);
		emit(encR({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'd3), 1'b1);
		storeResult(5'd3, exp);
	endtask

	task automatic aluI(input logic [2:0] f3, input logic [11:0] imm, input word_t exp);
		emit(encI(imm, 5'd1, f3, 5'd3, OPC_OPIMM), 1'b1);
		storeResult(5'd3, exp);
	endtask

	task automatic fillMemories();
		int i;
		for (i = 0; i < 4096; i++) begin
			u_iMem.mem[i] = 32'hc000_0000 | i;
			u_dMem.mem[i] = 32'hd000_0000 | i;
			expValid[i] = 1'b0;
		end
	endtask

	task automatic buildProgram();
		word_t a;
		word_t b;
		word_t u;
		word_t si;
		logic [11:0] i12;
		logic [4:0] ish;
		int jumpAt;
		a = nextRand();
		b = nextRand();
		if (b == a)
			b = ~a;
		u = nextRand();
		i12 = u[11:0];
		ish = u[16:12];
		si = {{20{i12[11]}}, i12};
		u_dMem.mem[0] = a;
		u_dMem.mem[1] = b;
		emit(encI(12'd0, 5'd0, 3'b010, 5'd1, OPC_LOAD), 1'b1);
		emit(encI(12'd4, 5'd0, 3'b010, 5'd2, OPC_LOAD), 1'b1);
		aluR(3'b000, 1'b0, a + b);
		aluR(3'b000, 1'b1, a - b);
		aluR(3'b001, 1'b0, a << b[4:0]);
		aluR(3'b010, 1'b0, lessSigned(a, b));
		aluR(3'b011, 1'b0, (a < b) ? 32'd1 : 32'd0);
		aluR(3'b100, 1'b0, a ^ b);
		aluR(3'b101, 1'b0, a >> b[4:0]);
		aluR(3'b101, 1'b1, shiftRightArith(a, b[4:0]));
		aluR(3'b110, 1'b0, a | b);
		aluR(3'b111, 1'b0, a & b);
		aluI(3'b000, i12, a + si);
		aluI(3'b010, i12, lessSigned(a, si));
		aluI(3'b011, i12, (a < si) ? 32'd1 : 32'd0);
		aluI(3'b100, i12, a ^ si);
		aluI(3'b110, i12, a | si);
		aluI(3'b111, i12, a & si);
		aluI(3'b001, {7'b0, ish}, a << ish);
		aluI(3'b101, {7'b0, ish}, a >> ish);
		aluI(3'b101, {7'b0100000, ish}, shiftRightArith(a, ish));
		u = nextRand();
		emit({u[31:12], 5'd3, OPC_LUI}, 1'b1);
		storeResult(5'd3, {u[31:12], 12'b0});
		// store, reload that slot, store to the next one
		storeResult(5'd1, a);
		emit(encI(12'(lastSlot), 5'd0, 3'b010, 5'd4, OPC_LOAD), 1'b1);
		storeResult(5'd4, a);
		storeResult(5'd2, b);
		emit(encI(12'(lastSlot), 5'd0, 3'b010, 5'd5, OPC_LOAD), 1'b1);
		storeResult(5'd5, b);
		// x7 collects a bit from each marked instruction that runs
		emit(encAddi(5'd7, 5'd0, 12'd0), 1'b1);
		emit(encB(13'd8, 5'd1, 5'd1, F3_BEQ), 1'b1);
		emit(encAddi(5'd7, 5'd7, 12'd1), 1'b0);
		emit(encB(13'd8, 5'd2, 5'd1, F3_BEQ), 1'b1);
		emit(encAddi(5'd7, 5'd7, 12'd2), 1'b1);
		emit(encB(13'd8, 5'd2, 5'd1, F3_BNE), 1'b1);
		emit(encAddi(5'd7, 5'd7, 12'd4), 1'b0);
		emit(encB(13'd8, 5'd1, 5'd1, F3_BNE), 1'b1);
		emit(encAddi(5'd7, 5'd7, 12'd8), 1'b1);
		jumpAt = progAddr;
		emit(encJ(21'd8, 5'd8), 1'b1);
		emit(encAddi(5'd7, 5'd7, 12'd16), 1'b0);
		storeResult(5'd8, word_t'(jumpAt + 4));
		// odd jalr sum so bit 0 must be cleared
		emit(encAddi(5'd9, 5'd0, 12'(progAddr + 9)), 1'b1);
		jumpAt = progAddr;
		emit(encI(12'd4, 5'd9, 3'b000, 5'd10, OPC_JALR), 1'b1);
		emit(encAddi(5'd7, 5'd7, 12'd32), 1'b0);
		storeResult(5'd10, word_t'(jumpAt + 4));
		storeResult(5'd7, 32'd10);
		emit(EBREAK_WORD, 1'b1);
	endtask

	always @(posedge CLK) begin
		if (rst) begin
			fetchIdx <= 0;
			storeCount <= 0;
		end else begin
			if (!iMemCsn)
				fetchIdx <= fetchIdx + 1;
			if (!dMemCsn && !dMemWen)
				storeCount <= storeCount + 1;
		end
	end

	assert property (@(posedge CLK) rst |=> (!rfWe && !halt && dMemWen && numInst == '0))
		else abortRun("control outputs not in their reset state after rst");
	assert property (@(posedge CLK) $fell(rst) |-> (!iMemCsn && iMemAddr == RESET_PC))
		else reportValue("iMemAddr", RESET_PC, $sampled(iMemAddr));
	assert property (@(posedge CLK) disable iff (rst)
		!iMemCsn |-> (fetchIdx < traceLen && iMemAddr == fetchTrace[fetchIdx]))
		else reportValue("iMemAddr", fetchTrace[$sampled(fetchIdx)], $sampled(iMemAddr));
	assert property (@(posedge CLK) disable iff (rst) rfWe |-> outputPort == rfWd)
		else reportValue("outputPort", $sampled(rfWd), $sampled(outputPort));
	assert property (@(posedge CLK) disable iff (rst) rfWe |-> rfWa != '0)
		else abortRun("register write targets x0");
	assert property (@(posedge CLK) disable iff (rst) !dMemCsn |-> dMemBe == 4'hf)
		else reportValue("dMemBe", 32'hf, $sampled(dMemBe));
	assert property (@(posedge CLK) disable iff (rst) !dMemWen |-> !dMemCsn)
		else abortRun("data memory write enable with chip select high");
	assert property (@(posedge CLK) disable iff (rst)
		(!dMemCsn && !dMemWen) |-> expValid[dMemAddr])
		else abortRun($sformatf("store to unexpected word address %h", $sampled(dMemAddr)));
	assert property (@(posedge CLK) disable iff (rst)
		(!dMemCsn && !dMemWen) |-> dMemDout == expData[dMemAddr])
		else reportValue("dMemDout", expData[$sampled(dMemAddr)], $sampled(dMemDout));
	assert property (@(posedge CLK) disable iff (rst) halt |-> (iMemCsn && dMemCsn))
		else abortRun("a memory is selected while halted");
	assert property (@(posedge CLK) disable iff (rst) halt |=> halt)
		else abortRun("halt dropped without reset");
	assert property (@(posedge CLK) disable iff (rst) $rose(halt) |-> numInst == expRetired)
		else reportValue("numInst", expRetired, $sampled(numInst));

	initial begin
		CLK = 1'b0;
		rst = 1'b1;
		progLoaded = 1'b0;
		rngState = 32'h51c198f9;
		traceLen = 0;
		expStores = 0;
		expRetired = 0;
		progAddr = 0;
		resultOff = 'h100;
		lastSlot = 0;
		fillMemories();
		buildProgram();
		timeoutCycles = traceLen * 5 + 40;
		progLoaded = 1'b1;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		wait (halt === 1'b1);
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		assert (fetchIdx == traceLen)
			else reportValue("fetch count", traceLen, fetchIdx);
		assert (storeCount == expStores)
			else reportValue("store count", expStores, storeCount);
		$display("Simulation PASSED");
		$finish;
	end

	// watchdog allows at most five cycles per instruction
	initial begin
		wait (progLoaded === 1'b1);
		repeat (timeoutCycles) @(posedge CLK);
		abortRun($sformatf("timeout, core did not halt within %0d cycles", timeoutCycles));
	end

endmodule

// ==== tb/riscvTbModels.sv ====
module riscvTbMem (
	input logic CLK,
	input logic csn,
	input logic wen,
	input riscvPkg::addr_t addr,
	input riscvPkg::word_t din,
	output riscvPkg::word_t dout
);
	import riscvPkg::*;

	word_t mem [0:4095];

	// read answers in the same cycle
	assign dout = mem[addr];

	always @(posedge CLK) begin
		if (!csn && !wen)
			mem[addr] <= din;
	end

endmodule

module riscvTbRegFile (
	input logic CLK,
	input logic we,
	input riscvPkg::regIdx_t ra1,
	input riscvPkg::regIdx_t ra2,
	input riscvPkg::regIdx_t wa,
	input riscvPkg::word_t wd,
	output riscvPkg::word_t rd1,
	output riscvPkg::word_t rd2
);
	import riscvPkg::*;

	word_t regs [0:31];

	// x0 always reads as zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

	always_ff @(posedge CLK) begin
		if (we && wa != '0)
			regs[wa] <= wd;
	end

endmodule
